/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    parameter int ADDR_W      = 16;
    parameter int WORD_W      = 16;
    parameter int LINE_W      = 64;
    parameter int NUM_SETS    = 8;
    parameter int NUM_WAYS    = 2;
    parameter int INDEX_W     = 3;
    parameter int OFFSET_W    = 2;
    parameter int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;  // 11
    parameter int LINE_ADDR_W = TAG_W + INDEX_W;              // 14

    parameter logic [LINE_ADDR_W-1:0] UNCACHED_LINE = 14'h3FFF;  // target of the all-ones address

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic                   write;
        logic [LINE_W-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } way_state_t;

    // way sits in the lsb so a plain increment walks ways before sets
    typedef struct packed {
        logic [INDEX_W-1:0] set_idx;
        logic               way;
    } flush_slot_t;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [OFFSET_W-1:0] addr_offset(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* dcache_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_core
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    output logic              cpu_done,
    output logic [WORD_W-1:0] cpu_rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ack,
    input  logic [LINE_W-1:0] mem_rdata,
    input  logic              slot_valid,
    input  flush_slot_t       slot,
    output logic              slot_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,  // tag compare on the latched request
        S_WB,      // victim writeback in flight
        S_FILL,    // refill read in flight
        S_UNC,     // uncacheable access in flight
        S_FLUSH    // flush writeback in flight
    } state_t;

    state_t            state;
    logic              victim;  // one global replacement bit
    way_state_t        ways  [NUM_SETS][NUM_WAYS];
    logic [LINE_W-1:0] lines [NUM_SETS][NUM_WAYS];

    cpu_req_t          req_q;
    flush_slot_t       slot_q;
    logic              slot_pend;  // slot waiting for the core to go idle

    logic [TAG_W-1:0]    req_tag;
    logic [INDEX_W-1:0]  req_idx;
    logic [OFFSET_W-1:0] req_off;
    logic                uncached;
    logic                hit0;
    logic                hit1;
    logic                hit;
    logic                hit_way;
    logic [LINE_W-1:0]   hit_line;
    way_state_t          vic_st;
    way_state_t          fl_st;
    logic                vic_dirty;
    logic                fl_dirty;

    logic     accept;
    logic     lookup;
    logic     hit_go;
    logic     start_unc;
    logic     start_wb;
    logic     start_fill;
    logic     fill_done;
    logic     unc_done;
    logic     take_slot;
    logic     start_fwb;
    logic     fwb_done;
    logic     mem_issue;
    mem_req_t mem_req_d;

    assign req_tag  = addr_tag(req_q.addr);
    assign req_idx  = addr_index(req_q.addr);
    assign req_off  = addr_offset(req_q.addr);
    assign uncached = &req_q.addr;

    assign hit0     = ways[req_idx][0].valid && (ways[req_idx][0].tag == req_tag);
    assign hit1     = ways[req_idx][1].valid && (ways[req_idx][1].tag == req_tag);
    assign hit      = hit0 | hit1;
    assign hit_way  = hit1;
    assign hit_line = lines[req_idx][hit_way];

    assign vic_st    = ways[req_idx][victim];
    assign vic_dirty = vic_st.valid & vic_st.dirty;
    assign fl_st     = ways[slot_q.set_idx][slot_q.way];
    assign fl_dirty  = fl_st.valid & fl_st.dirty;

    assign accept    = (state == S_IDLE) & cpu_valid;
    assign lookup    = (state == S_LOOKUP);
    assign hit_go    = lookup & ~uncached & hit;
    assign start_unc = lookup & uncached;
    assign start_wb  = lookup & ~uncached & ~hit & vic_dirty;
    assign start_fill = (lookup & ~uncached & ~hit & ~vic_dirty)
                      | ((state == S_WB) & mem_ack);  // refill right after the writeback
    assign fill_done = (state == S_FILL) & mem_ack;
    assign unc_done  = (state == S_UNC) & mem_ack;
    assign take_slot = (state == S_IDLE) & ~cpu_valid & slot_pend;  // cpu request wins
    assign start_fwb = take_slot & fl_dirty;
    assign fwb_done  = (state == S_FLUSH) & mem_ack;
    assign mem_issue = start_wb | start_fill | start_unc | start_fwb;

    always_comb begin
        mem_req_d.line_addr = {req_tag, req_idx};  // refill read by default
        mem_req_d.write     = 1'b0;
        mem_req_d.wdata     = '0;
        if (start_wb) begin
            mem_req_d.line_addr = {vic_st.tag, req_idx};
            mem_req_d.write     = 1'b1;
            mem_req_d.wdata     = lines[req_idx][victim];
        end else if (start_unc) begin
            mem_req_d.line_addr = UNCACHED_LINE;
            mem_req_d.write     = req_q.write;
            mem_req_d.wdata     = LINE_W'(req_q.wdata);  // zero-extended word
        end else if (start_fwb) begin
            mem_req_d.line_addr = {fl_st.tag, slot_q.set_idx};
            mem_req_d.write     = 1'b1;
            mem_req_d.wdata     = lines[slot_q.set_idx][slot_q.way];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= S_IDLE;
            victim    <= 1'b0;
            cpu_done  <= 1'b0;
            mem_valid <= 1'b0;
            slot_done <= 1'b0;
            slot_pend <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    ways[s][w] <= '0;
                end
            end
        end else begin
            cpu_done  <= hit_go | unc_done;
            mem_valid <= mem_issue;
            slot_done <= (take_slot & ~fl_dirty) | fwb_done;  // clean slots skip memory

            if (slot_valid) begin
                slot_pend <= 1'b1;
            end else if (take_slot) begin
                slot_pend <= 1'b0;
            end

            if (hit_go && req_q.write) begin
                ways[req_idx][hit_way].dirty <= 1'b1;
            end
            if (fill_done) begin
                ways[req_idx][victim] <= '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
                victim                <= ~victim;
            end
            if (fwb_done) begin
                ways[slot_q.set_idx][slot_q.way].dirty <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end else if (start_fwb) begin
                        state <= S_FLUSH;
                    end
                end
                S_LOOKUP: begin
                    if (start_unc) begin
                        state <= S_UNC;
                    end else if (start_wb) begin
                        state <= S_WB;
                    end else if (!hit) begin
                        state <= S_FILL;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_WB: begin
                    if (mem_ack) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (mem_ack) begin
                        state <= S_LOOKUP;  // replay the access on the new line
                    end
                end
                S_UNC, S_FLUSH: begin
                    if (mem_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (slot_valid) begin
            slot_q <= slot;
        end
        if (mem_issue) begin
            mem_req <= mem_req_d;
        end

        if (hit_go) begin
            cpu_rdata <= hit_line[req_off*WORD_W +: WORD_W];
        end else if (unc_done) begin
            cpu_rdata <= mem_rdata[WORD_W-1:0];  // low word of the uncached line
        end

        if (hit_go && req_q.write) begin
            lines[req_idx][hit_way][req_off*WORD_W +: WORD_W] <= req_q.wdata;
        end
        if (fill_done) begin
            lines[req_idx][victim] <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* flush_walker.sv */
`timescale 1ns/1ns
`default_nettype none

module flush_walker
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        slot_done,
    output logic        slot_valid,
    output flush_slot_t slot,
    output logic        flush_done
);

    localparam flush_slot_t LAST_SLOT = '{set_idx: INDEX_W'(NUM_SETS - 1), way: 1'b1};

    logic               busy;
    logic [INDEX_W:0]   cnt;  // {set, way}, way toggles first
    logic               last;

    assign slot = flush_slot_t'(cnt);
    assign last = (slot == LAST_SLOT);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy       <= 1'b0;
            cnt        <= '0;
            slot_valid <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            slot_valid <= 1'b0;
            flush_done <= 1'b0;
            if (!busy) begin
                if (flush) begin
                    busy       <= 1'b1;
                    cnt        <= '0;
                    slot_valid <= 1'b1;  // first slot goes out right away
                end
            end else if (slot_done) begin
                if (last) begin
                    busy       <= 1'b0;
                    flush_done <= 1'b1;
                end else begin
                    cnt        <= cnt + 1'b1;
                    slot_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* main_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module main_mem
    import dcache_pkg::*;
#(
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid,
    input  mem_req_t          mem_req,
    output logic              mem_ack,
    output logic [LINE_W-1:0] mem_rdata
);

    localparam int CNT_W = $clog2(MEM_LATENCY) + 1;

    logic [LINE_W-1:0] ram [2**LINE_ADDR_W];
    mem_req_t          req_q;
    mem_req_t          cur;
    logic              busy;
    logic [CNT_W-1:0]  cnt;  // cycles since mem_valid
    logic              due;

    // a one-cycle latency is served straight from the request port
    assign cur = mem_valid ? mem_req : req_q;
    assign due = (mem_valid && (MEM_LATENCY == 1))
               || (busy && (cnt == CNT_W'(MEM_LATENCY - 1)));

    initial begin
        for (int i = 0; i < 2**LINE_ADDR_W; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= due;
            if (mem_valid) begin
                busy <= (MEM_LATENCY > 1);
                cnt  <= CNT_W'(1);
            end else if (due) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            req_q <= mem_req;
        end
        if (due) begin
            if (cur.write) begin
                ram[cur.line_addr] <= cur.wdata;
            end
            mem_rdata <= ram[cur.line_addr];  // only meaningful for reads
        end
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int MEM_LATENCY = 3  // at least 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    output logic              cpu_done,
    output logic [WORD_W-1:0] cpu_rdata,
    input  logic              flush,
    output logic              flush_done
);

    logic              mem_valid;
    mem_req_t          mem_req;
    logic              mem_ack;
    logic [LINE_W-1:0] mem_rdata;
    logic              slot_valid;
    flush_slot_t       slot;
    logic              slot_done;

    dcache_core dcache_core_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_req    (cpu_req),
        .cpu_done   (cpu_done),
        .cpu_rdata  (cpu_rdata),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .slot_valid (slot_valid),
        .slot       (slot),
        .slot_done  (slot_done)
    );

    flush_walker flush_walker_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .slot_done  (slot_done),
        .slot_valid (slot_valid),
        .slot       (slot),
        .flush_done (flush_done)
    );

    main_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) main_mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          TIMEOUT   = 200;
    localparam int          POOL_SIZE = 40;
    localparam int          MIX_OPS   = 300;
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;  // x^32 + x^30 + x^26 + x^25 + 1

    logic              clk;
    logic              rst;
    logic              cpu_valid;
    cpu_req_t          cpu_req;
    logic              cpu_done;
    logic [WORD_W-1:0] cpu_rdata;
    logic              flush;
    logic              flush_done;

    logic [31:0] lfsr_state;
    logic [15:0] model_mem [logic [15:0]];  // word-addressed reference memory
    logic [15:0] pool [POOL_SIZE];
    logic [15:0] written [$];

    dcache_top #(
        .MEM_LATENCY (3)
    ) dcache_top_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_req    (cpu_req),
        .cpu_done   (cpu_done),
        .cpu_rdata  (cpu_rdata),
        .flush      (flush),
        .flush_done (flush_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] random_addr();
        logic [15:0] a;
        a = 16'(take_bits(16));
        if (a[15:2] == UNCACHED_LINE) begin
            a[15] = 1'b0;  // stay off the uncached line
        end
        return a;
    endfunction

    function automatic logic [15:0] expected_word(input logic [15:0] addr);
        logic [15:0] key;
        key = (addr == 16'hFFFF) ? 16'hFFFC : addr;  // uncached read gives word 0 of the line
        return model_mem.exists(key) ? model_mem[key] : 16'h0000;
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [15:0] data);
        if (addr == 16'hFFFF) begin
            // whole line replaced by the zero-extended word
            model_mem[16'hFFFC] = data;
            model_mem[16'hFFFD] = 16'h0000;
            model_mem[16'hFFFE] = 16'h0000;
            model_mem[16'hFFFF] = 16'h0000;
        end else begin
            model_mem[addr] = data;
        end
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%04h, expected 0x%04h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // called on a falling edge, returns on the falling edge that sees cpu_done
    task automatic cpu_access(input logic [15:0] addr, input logic wr, input logic [15:0] wdata,
                              output logic [15:0] rdata, output int cycles);
        int   n;
        logic seen;
        cpu_valid = 1'b1;
        cpu_req   = '{addr: addr, write: wr, wdata: wdata};
        n         = 0;
        seen      = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            cpu_valid = 1'b0;
            n++;
            seen = cpu_done;
        end
        assert (seen) else begin
            $display("timeout: no cpu_done within %0d cycles for address 0x%04h", TIMEOUT, addr);
            $display("TEST FAIL");
            $fatal(1, "cpu_done wait expired");
        end
        rdata  = cpu_rdata;
        cycles = n;
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
        logic [15:0] rd;
        int          cyc;
        model_write(addr, data);
        cpu_access(addr, 1'b1, data, rd, cyc);
    endtask

    task automatic read_check(input logic [15:0] addr, output int cycles);
        logic [15:0] rd;
        cpu_access(addr, 1'b0, 16'h0000, rd, cycles);
        check_value($sformatf("cpu_rdata at 0x%04h", addr), rd, expected_word(addr));
    endtask

    task automatic run_flush();
        int   n;
        logic seen;
        flush = 1'b1;
        n     = 0;
        seen  = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            flush = 1'b0;
            n++;
            seen = flush_done;
        end
        assert (seen) else begin
            $display("timeout: no flush_done within %0d cycles", TIMEOUT);
            $display("TEST FAIL");
            $fatal(1, "flush_done wait expired");
        end
    endtask

    initial begin
        logic [15:0] a;
        logic [10:0] t0;
        logic [2:0]  idx;
        logic [1:0]  off;
        logic [15:0] trio [3];
        int          cycles;
        int          sel;
        int          i;
        rst        = 1'b0;
        cpu_valid  = 1'b0;
        cpu_req    = '0;
        flush      = 1'b0;
        lfsr_state = 32'd82118;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // cold read goes to memory and sees zero
        a = random_addr();
        read_check(a, cycles);
        assert (cycles > 2) else begin
            $display("cold read at 0x%04h answered as fast as a hit", a);
            $display("TEST FAIL");
            $fatal(1, "miss path not taken");
        end

        // write then read back, second access hits
        a = random_addr();
        write_word(a, 16'(take_bits(16)));
        read_check(a, cycles);
        check_value("cpu_done delay", 16'(cycles), 16'd2);

        // three tags in one set, third write evicts a dirty way
        idx = 3'(take_bits(3));
        off = 2'(take_bits(2));
        t0  = 11'(take_bits(10));  // msb clear keeps t0 + 2 below the all-ones tag
        for (i = 0; i < 3; i++) begin
            trio[i] = {t0 + 11'(i), idx, off};
            write_word(trio[i], 16'(take_bits(16)));
        end
        for (i = 0; i < 3; i++) begin
            read_check(trio[i], cycles);
        end

        // uncached address
        read_check(16'hFFFF, cycles);
        write_word(16'hFFFF, 16'(take_bits(16)));
        read_check(16'hFFFF, cycles);

        // dirty lines, then flush
        for (i = 0; i < 12; i++) begin
            a = random_addr();
            written.push_back(a);
            write_word(a, 16'(take_bits(16)));
        end
        run_flush();
        foreach (written[j]) begin
            read_check(written[j], cycles);
        end
        run_flush();  // all lines clean this time
        foreach (written[j]) begin
            read_check(written[j], cycles);
        end

        // long mix over a small address pool
        for (i = 0; i < POOL_SIZE; i++) begin
            pool[i] = random_addr();
        end
        for (i = 0; i < MIX_OPS; i++) begin
            sel = int'(take_bits(6)) % POOL_SIZE;
            if (take_bits(1) != 32'd0) begin
                write_word(pool[sel], 16'(take_bits(16)));
            end else begin
                read_check(pool[sel], cycles);
            end
        end

        // reads now refill the flushed lines from memory
        foreach (written[j]) begin
            read_check(written[j], cycles);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_sub.f */
dcache_pkg.sv
dcache_core.sv
flush_walker.sv
main_mem.sv
dcache_top.sv
tb_dcache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dcache
FILELIST   := dcache_sub.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
